// ==== Bender.yml ====
package:
  name: snoop_interconnect

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/snoop_pkg.sv
      - design/snoop_fifo.sv
      - design/snoop_req_arbiter.sv
      - design/snoop_port.sv
      - design/snoop_resp_merger.sv
      - design/snoop_interconnect.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_snoop_interconnect.sv

// ==== all.f ====
+incdir+design
design/snoop_pkg.sv
design/snoop_fifo.sv
design/snoop_req_arbiter.sv
design/snoop_port.sv
design/snoop_resp_merger.sv
design/snoop_interconnect.sv
test/tb_snoop_interconnect.sv

// ==== design/snoop_cfg.svh ====
`ifndef SNOOP_CFG_SVH
`define SNOOP_CFG_SVH

// Requesters and snooper ports
`define SNOOP_NUM_INP 3
`define SNOOP_NUM_OUP 4

// Channel widths
`define SNOOP_ADDR_W 32
`define SNOOP_TYPE_W 4
// CR bits are data transfer, error, pass dirty, is shared and was unique
`define SNOOP_RESP_W 5

// Conflict-monitor address slice
`define SNOOP_CM_ADDR_W 12
`define SNOOP_CM_ADDR_BASE 6

// Buffer depths and per-port credit limit
`define SNOOP_CTRL_DEPTH 4
`define SNOOP_PORT_DEPTH 2
`define SNOOP_PORT_MAX_OUT 3

`endif

// ==== design/snoop_fifo.sv ====
`timescale 1ns/1ps

module snoop_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 2
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             valid_i,
    output logic             ready_o,
    input  logic [WIDTH-1:0] data_i,
    output logic             valid_o,
    input  logic             ready_i,
    output logic [WIDTH-1:0] data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign ready_o = (count != CNT_W'(DEPTH));
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];

    assign push = valid_i && ready_o;
    assign pop  = valid_o && ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

// ==== design/snoop_interconnect.sv ====
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_interconnect import snoop_pkg::*; (
    input  logic                              clk_i,
    input  logic                              arst_n_i,

    input  logic        [`SNOOP_NUM_INP-1:0]  inp_ac_valid_i,
    input  snoop_addr_t [`SNOOP_NUM_INP-1:0]  inp_ac_addr_i,
    input  snoop_type_t [`SNOOP_NUM_INP-1:0]  inp_ac_type_i,
    input  oup_sel_t    [`SNOOP_NUM_INP-1:0]  inp_sel_i,
    output logic        [`SNOOP_NUM_INP-1:0]  inp_ac_ready_o,
    output logic        [`SNOOP_NUM_INP-1:0]  inp_cr_valid_o,
    output snoop_resp_t [`SNOOP_NUM_INP-1:0]  inp_cr_resp_o,
    input  logic        [`SNOOP_NUM_INP-1:0]  inp_cr_ready_i,

    output logic        [`SNOOP_NUM_OUP-1:0]  oup_ac_valid_o,
    output snoop_addr_t [`SNOOP_NUM_OUP-1:0]  oup_ac_addr_o,
    output snoop_type_t [`SNOOP_NUM_OUP-1:0]  oup_ac_type_o,
    input  logic        [`SNOOP_NUM_OUP-1:0]  oup_ac_ready_i,
    input  logic        [`SNOOP_NUM_OUP-1:0]  oup_cr_valid_i,
    input  snoop_resp_t [`SNOOP_NUM_OUP-1:0]  oup_cr_resp_i,
    output logic        [`SNOOP_NUM_OUP-1:0]  oup_cr_ready_o,

    output logic                              cm_valid_o,
    output cm_addr_t                          cm_addr_o,
    input  logic                              cm_stall_i
);

    localparam int unsigned CTRL_W = `SNOOP_NUM_OUP + $bits(inp_idx_t);

    oup_sel_t    fork_valid;
    oup_sel_t    fork_ready;
    snoop_addr_t fork_addr;
    snoop_type_t fork_type;

    logic        ctrl_push_valid;
    logic        ctrl_push_ready;
    oup_sel_t    ctrl_push_sel;
    inp_idx_t    ctrl_push_idx;
    logic        ctrl_pop_valid;
    logic        ctrl_pop_ready;
    oup_sel_t    ctrl_pop_sel;
    inp_idx_t    ctrl_pop_idx;

    oup_sel_t                         port_cr_valid;
    oup_sel_t                         port_cr_ready;
    snoop_resp_t [`SNOOP_NUM_OUP-1:0] port_cr_resp;

    snoop_req_arbiter i_arbiter (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .inp_ac_valid_i (inp_ac_valid_i),
        .inp_ac_addr_i  (inp_ac_addr_i),
        .inp_ac_type_i  (inp_ac_type_i),
        .inp_sel_i      (inp_sel_i),
        .inp_ac_ready_o (inp_ac_ready_o),
        .cm_stall_i     (cm_stall_i),
        .cm_valid_o     (cm_valid_o),
        .cm_addr_o      (cm_addr_o),
        .fork_valid_o   (fork_valid),
        .fork_addr_o    (fork_addr),
        .fork_type_o    (fork_type),
        .fork_ready_i   (fork_ready),
        .ctrl_valid_o   (ctrl_push_valid),
        .ctrl_sel_o     (ctrl_push_sel),
        .ctrl_idx_o     (ctrl_push_idx),
        .ctrl_ready_i   (ctrl_push_ready)
    );

    // Keeps grant order for the response side
    snoop_fifo #(
        .WIDTH (CTRL_W),
        .DEPTH (`SNOOP_CTRL_DEPTH)
    ) i_ctrl_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (ctrl_push_valid),
        .ready_o  (ctrl_push_ready),
        .data_i   ({ctrl_push_sel, ctrl_push_idx}),
        .valid_o  (ctrl_pop_valid),
        .ready_i  (ctrl_pop_ready),
        .data_o   ({ctrl_pop_sel, ctrl_pop_idx})
    );

    for (genvar i = 0; i < `SNOOP_NUM_OUP; i++) begin : gen_port
        snoop_port i_port (
            .clk_i           (clk_i),
            .arst_n_i        (arst_n_i),
            .fork_valid_i    (fork_valid[i]),
            .fork_addr_i     (fork_addr),
            .fork_type_i     (fork_type),
            .fork_ready_o    (fork_ready[i]),
            .oup_ac_valid_o  (oup_ac_valid_o[i]),
            .oup_ac_addr_o   (oup_ac_addr_o[i]),
            .oup_ac_type_o   (oup_ac_type_o[i]),
            .oup_ac_ready_i  (oup_ac_ready_i[i]),
            .oup_cr_valid_i  (oup_cr_valid_i[i]),
            .oup_cr_resp_i   (oup_cr_resp_i[i]),
            .oup_cr_ready_o  (oup_cr_ready_o[i]),
            .port_cr_valid_o (port_cr_valid[i]),
            .port_cr_resp_o  (port_cr_resp[i]),
            .port_cr_ready_i (port_cr_ready[i])
        );
    end

    snoop_resp_merger i_merger (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .ctrl_valid_i    (ctrl_pop_valid),
        .ctrl_sel_i      (ctrl_pop_sel),
        .ctrl_idx_i      (ctrl_pop_idx),
        .ctrl_ready_o    (ctrl_pop_ready),
        .port_cr_valid_i (port_cr_valid),
        .port_cr_resp_i  (port_cr_resp),
        .port_cr_ready_o (port_cr_ready),
        .inp_cr_valid_o  (inp_cr_valid_o),
        .inp_cr_resp_o   (inp_cr_resp_o),
        .inp_cr_ready_i  (inp_cr_ready_i)
    );

endmodule

// ==== design/snoop_pkg.sv ====
`include "snoop_cfg.svh"

package snoop_pkg;

    typedef logic [`SNOOP_ADDR_W-1:0] snoop_addr_t;
    typedef logic [`SNOOP_TYPE_W-1:0] snoop_type_t;
    typedef logic [`SNOOP_RESP_W-1:0] snoop_resp_t;

    // One bit per snooper port
    typedef logic [`SNOOP_NUM_OUP-1:0] oup_sel_t;

    typedef logic [$clog2(`SNOOP_NUM_INP)-1:0] inp_idx_t;

    typedef logic [`SNOOP_CM_ADDR_W-1:0] cm_addr_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FORK,
        ARB_CTRL
    } arb_state_e;

endpackage

// ==== design/snoop_port.sv ====
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_port import snoop_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        fork_valid_i,
    input  snoop_addr_t fork_addr_i,
    input  snoop_type_t fork_type_i,
    output logic        fork_ready_o,
    output logic        oup_ac_valid_o,
    output snoop_addr_t oup_ac_addr_o,
    output snoop_type_t oup_ac_type_o,
    input  logic        oup_ac_ready_i,
    input  logic        oup_cr_valid_i,
    input  snoop_resp_t oup_cr_resp_i,
    output logic        oup_cr_ready_o,
    output logic        port_cr_valid_o,
    output snoop_resp_t port_cr_resp_o,
    input  logic        port_cr_ready_i
);

    localparam int unsigned REQ_W = `SNOOP_ADDR_W + `SNOOP_TYPE_W;
    localparam int unsigned CNT_W = $clog2(`SNOOP_PORT_MAX_OUT + 1);

    logic [CNT_W-1:0] out_cnt;
    logic             credit_ok;
    logic             req_ready;
    logic             accept;
    logic             port_done;

    assign credit_ok    = (out_cnt < CNT_W'(`SNOOP_PORT_MAX_OUT));
    assign fork_ready_o = credit_ok && req_ready;
    assign accept       = fork_valid_i && fork_ready_o;
    // Credit returns once the merger takes the response
    assign port_done    = port_cr_valid_o && port_cr_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_cnt <= '0;
        end else if (accept && !port_done) begin
            out_cnt <= out_cnt + 1'b1;
        end else if (port_done && !accept) begin
            out_cnt <= out_cnt - 1'b1;
        end
    end

    snoop_fifo #(
        .WIDTH (REQ_W),
        .DEPTH (`SNOOP_PORT_DEPTH)
    ) i_req_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (fork_valid_i && credit_ok),
        .ready_o  (req_ready),
        .data_i   ({fork_addr_i, fork_type_i}),
        .valid_o  (oup_ac_valid_o),
        .ready_i  (oup_ac_ready_i),
        .data_o   ({oup_ac_addr_o, oup_ac_type_o})
    );

    snoop_fifo #(
        .WIDTH (`SNOOP_RESP_W),
        .DEPTH (`SNOOP_PORT_DEPTH)
    ) i_resp_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (oup_cr_valid_i),
        .ready_o  (oup_cr_ready_o),
        .data_i   (oup_cr_resp_i),
        .valid_o  (port_cr_valid_o),
        .ready_i  (port_cr_ready_i),
        .data_o   (port_cr_resp_o)
    );

endmodule

// ==== design/snoop_req_arbiter.sv ====
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_req_arbiter import snoop_pkg::*; (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic        [`SNOOP_NUM_INP-1:0]  inp_ac_valid_i,
    input  snoop_addr_t [`SNOOP_NUM_INP-1:0]  inp_ac_addr_i,
    input  snoop_type_t [`SNOOP_NUM_INP-1:0]  inp_ac_type_i,
    input  oup_sel_t    [`SNOOP_NUM_INP-1:0]  inp_sel_i,
    output logic        [`SNOOP_NUM_INP-1:0]  inp_ac_ready_o,
    input  logic                              cm_stall_i,
    output logic                              cm_valid_o,
    output cm_addr_t                          cm_addr_o,
    output oup_sel_t                          fork_valid_o,
    output snoop_addr_t                       fork_addr_o,
    output snoop_type_t                       fork_type_o,
    input  oup_sel_t                          fork_ready_i,
    output logic                              ctrl_valid_o,
    output oup_sel_t                          ctrl_sel_o,
    output inp_idx_t                          ctrl_idx_o,
    input  logic                              ctrl_ready_i
);

    arb_state_e  state;
    inp_idx_t    rr_ptr;
    inp_idx_t    pick_idx;
    logic        pick_found;
    int          cand;

    inp_idx_t    win_idx;
    snoop_addr_t win_addr;
    snoop_type_t win_type;
    oup_sel_t    win_sel;
    oup_sel_t    done_mask;
    oup_sel_t    fork_acc;
    oup_sel_t    fork_next;

    // First valid requester after the last grant
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        for (int k = 1; k <= `SNOOP_NUM_INP; k++) begin
            cand = (int'(rr_ptr) + k) % `SNOOP_NUM_INP;
            if (!pick_found && inp_ac_valid_i[cand]) begin
                pick_found = 1'b1;
                pick_idx   = inp_idx_t'(cand);
            end
        end
    end

    assign cm_valid_o = (state == ARB_FORK);
    assign cm_addr_o  = win_addr[`SNOOP_CM_ADDR_BASE +: `SNOOP_CM_ADDR_W];

    assign fork_valid_o = (state == ARB_FORK && !cm_stall_i) ? (win_sel & ~done_mask) : '0;
    assign fork_addr_o  = win_addr;
    assign fork_type_o  = win_type;
    assign fork_acc     = fork_valid_o & fork_ready_i;
    assign fork_next    = done_mask | fork_acc;

    assign ctrl_valid_o = (state == ARB_CTRL);
    assign ctrl_sel_o   = win_sel;
    assign ctrl_idx_o   = win_idx;

    always_comb begin
        inp_ac_ready_o = '0;
        if (state == ARB_CTRL && ctrl_ready_i) begin
            inp_ac_ready_o[win_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state     <= ARB_IDLE;
            rr_ptr    <= inp_idx_t'(`SNOOP_NUM_INP - 1);
            done_mask <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_found) begin
                        rr_ptr    <= pick_idx;
                        done_mask <= '0;
                        state     <= (inp_sel_i[pick_idx] == '0) ? ARB_CTRL : ARB_FORK;
                    end
                end
                ARB_FORK: begin
                    if (!cm_stall_i) begin
                        done_mask <= fork_next;
                        if (fork_next == win_sel) begin
                            state <= ARB_CTRL;
                        end
                    end
                end
                ARB_CTRL: begin
                    if (ctrl_ready_i) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Latch the winner's request
    always_ff @(posedge clk_i) begin
        if (state == ARB_IDLE && pick_found) begin
            win_idx  <= pick_idx;
            win_addr <= inp_ac_addr_i[pick_idx];
            win_type <= inp_ac_type_i[pick_idx];
            win_sel  <= inp_sel_i[pick_idx];
        end
    end

endmodule

// ==== design/snoop_resp_merger.sv ====
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module snoop_resp_merger import snoop_pkg::*; (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              ctrl_valid_i,
    input  oup_sel_t                          ctrl_sel_i,
    input  inp_idx_t                          ctrl_idx_i,
    output logic                              ctrl_ready_o,
    input  oup_sel_t                          port_cr_valid_i,
    input  snoop_resp_t [`SNOOP_NUM_OUP-1:0]  port_cr_resp_i,
    output oup_sel_t                          port_cr_ready_o,
    output logic        [`SNOOP_NUM_INP-1:0]  inp_cr_valid_o,
    output snoop_resp_t [`SNOOP_NUM_INP-1:0]  inp_cr_resp_o,
    input  logic        [`SNOOP_NUM_INP-1:0]  inp_cr_ready_i
);

    oup_sel_t    coll_mask;
    snoop_resp_t acc_resp;
    oup_sel_t    take;
    snoop_resp_t take_or;
    logic        complete;
    logic        deliver;

    // Only ports of the head entry that have not answered yet
    assign port_cr_ready_o = ctrl_valid_i ? (ctrl_sel_i & ~coll_mask) : '0;
    assign take            = port_cr_valid_i & port_cr_ready_o;

    always_comb begin
        take_or = '0;
        for (int i = 0; i < `SNOOP_NUM_OUP; i++) begin
            if (take[i]) begin
                take_or = take_or | port_cr_resp_i[i];
            end
        end
    end

    // A zero mask completes as soon as the entry is at the head
    assign complete = ctrl_valid_i && (coll_mask == ctrl_sel_i);
    assign deliver  = complete && inp_cr_ready_i[ctrl_idx_i];

    assign ctrl_ready_o = deliver;

    always_comb begin
        inp_cr_valid_o = '0;
        if (complete) begin
            inp_cr_valid_o[ctrl_idx_i] = 1'b1;
        end
    end

    always_comb begin
        for (int j = 0; j < `SNOOP_NUM_INP; j++) begin
            inp_cr_resp_o[j] = acc_resp;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            coll_mask <= '0;
            acc_resp  <= '0;
        end else if (deliver) begin
            coll_mask <= '0;
            acc_resp  <= '0;
        end else begin
            coll_mask <= coll_mask | take;
            acc_resp  <= acc_resp | take_or;
        end
    end

endmodule

// ==== test/tb_snoop_interconnect.sv ====
`timescale 1ns/1ps
`include "snoop_cfg.svh"

module tb_snoop_interconnect import snoop_pkg::*; ();

    localparam int ACK_TIMEOUT   = 2000;
    localparam int ISSUE_TIMEOUT = 40000;
    localparam int DRAIN_TIMEOUT = 8000;

    logic                              clk_i;
    logic                              arst_n_i;
    logic        [`SNOOP_NUM_INP-1:0]  inp_ac_valid_i;
    snoop_addr_t [`SNOOP_NUM_INP-1:0]  inp_ac_addr_i;
    snoop_type_t [`SNOOP_NUM_INP-1:0]  inp_ac_type_i;
    oup_sel_t    [`SNOOP_NUM_INP-1:0]  inp_sel_i;
    logic        [`SNOOP_NUM_INP-1:0]  inp_ac_ready_o;
    logic        [`SNOOP_NUM_INP-1:0]  inp_cr_valid_o;
    snoop_resp_t [`SNOOP_NUM_INP-1:0]  inp_cr_resp_o;
    logic        [`SNOOP_NUM_INP-1:0]  inp_cr_ready_i;
    logic        [`SNOOP_NUM_OUP-1:0]  oup_ac_valid_o;
    snoop_addr_t [`SNOOP_NUM_OUP-1:0]  oup_ac_addr_o;
    snoop_type_t [`SNOOP_NUM_OUP-1:0]  oup_ac_type_o;
    logic        [`SNOOP_NUM_OUP-1:0]  oup_ac_ready_i;
    logic        [`SNOOP_NUM_OUP-1:0]  oup_cr_valid_i;
    snoop_resp_t [`SNOOP_NUM_OUP-1:0]  oup_cr_resp_i;
    logic        [`SNOOP_NUM_OUP-1:0]  oup_cr_ready_o;
    logic                              cm_valid_o;
    cm_addr_t                          cm_addr_o;
    logic                              cm_stall_i;

    int          err_cnt;
    int          resp_cnt;
    int          tests_run;
    int          tests_failed;
    int          issuers_done;
    bit          timed_out;
    bit          stress_mode;
    bit          cm_seen;
    cm_addr_t    last_cm_addr;
    int          grant_idx_q [$];
    oup_sel_t    grant_sel_q [$];
    // Per-port queues of owed snoops, seen snoops and snooper answers
    logic [63:0] exp_ac_q [`SNOOP_NUM_OUP][$];
    logic [63:0] obs_ac_q [`SNOOP_NUM_OUP][$];
    snoop_resp_t given_q  [`SNOOP_NUM_OUP][$];
    int          ac_cnt   [`SNOOP_NUM_OUP];
    int          cr_cnt   [`SNOOP_NUM_OUP];

    snoop_interconnect dut (.*);

    always #5 clk_i = ~clk_i;

    task automatic report_mismatch(input string sig, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        err_cnt++;
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, sig, exp_val, act_val);
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("error at t=%0t: %s", $time, msg);
    endtask

    task automatic report_test(input string name, input int snoops, input int err_start);
        int errs;
        errs = err_cnt - err_start;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-15s %4d snoops %3d errors  %s", name, snoops, errs,
                 (errs == 0) ? "ok" : "failed");
    endtask

    task automatic record_grant(input int r);
        snoop_addr_t addr;
        oup_sel_t    sel;
        logic [63:0] ac_word;
        addr    = inp_ac_addr_i[r];
        sel     = inp_sel_i[r];
        ac_word = {addr, inp_ac_type_i[r]};
        grant_idx_q.push_back(r);
        grant_sel_q.push_back(sel);
        for (int p = 0; p < `SNOOP_NUM_OUP; p++) begin
            if (sel[p]) begin
                exp_ac_q[p].push_back(ac_word);
            end
        end
        if (sel != '0) begin
            assert (cm_seen)
                else report_problem($sformatf("no cm_valid_o before grant to requester %0d", r));
            assert (last_cm_addr == addr[`SNOOP_CM_ADDR_BASE +: `SNOOP_CM_ADDR_W])
                else report_mismatch("cm_addr_o", addr[`SNOOP_CM_ADDR_BASE +: `SNOOP_CM_ADDR_W],
                                     last_cm_addr);
        end else begin
            assert (!cm_seen) else report_problem("cm_valid_o raised for a zero-mask snoop");
        end
        cm_seen = 1'b0;
    endtask

    task automatic check_response(input int r);
        int          idx;
        oup_sel_t    sel;
        snoop_resp_t exp_resp;
        exp_resp = '0;
        if (grant_idx_q.size() == 0) begin
            report_problem($sformatf("requester %0d got a response with no snoop pending", r));
        end else begin
            idx = grant_idx_q.pop_front();
            sel = grant_sel_q.pop_front();
            // Expected answer is the OR over the selected snoopers
            for (int p = 0; p < `SNOOP_NUM_OUP; p++) begin
                if (sel[p]) begin
                    if (given_q[p].size() == 0) begin
                        report_problem($sformatf("response merged before snooper %0d answered", p));
                    end else begin
                        exp_resp = exp_resp | given_q[p].pop_front();
                    end
                end
            end
            assert (idx == r) else report_mismatch("inp_cr_valid_o requester", idx, r);
            assert (inp_cr_resp_o[r] == exp_resp)
                else report_mismatch($sformatf("inp_cr_resp_o[%0d]", r), exp_resp, inp_cr_resp_o[r]);
        end
        resp_cnt++;
    endtask

    // Handshakes seen here complete on the next rising edge
    always @(negedge clk_i) begin
        logic [63:0] exp_word;
        logic [63:0] obs_word;
        if (arst_n_i) begin
            if (cm_valid_o) begin
                cm_seen      = 1'b1;
                last_cm_addr = cm_addr_o;
            end
            for (int r = 0; r < `SNOOP_NUM_INP; r++) begin
                assert (!inp_ac_ready_o[r] || inp_ac_valid_i[r])
                    else report_problem($sformatf("inp_ac_ready_o[%0d] with no request", r));
                if (inp_ac_valid_i[r] && inp_ac_ready_o[r]) begin
                    record_grant(r);
                end
            end
            for (int p = 0; p < `SNOOP_NUM_OUP; p++) begin
                // A full response buffer holds at least its depth of unmerged answers
                assert (oup_cr_ready_o[p] || given_q[p].size() >= `SNOOP_PORT_DEPTH)
                    else report_problem($sformatf("oup_cr_ready_o[%0d] low with room in the buffer",
                                                  p));
                if (oup_ac_valid_o[p] && oup_ac_ready_i[p]) begin
                    obs_ac_q[p].push_back({oup_ac_addr_o[p], oup_ac_type_o[p]});
                    ac_cnt[p]++;
                end
                if (oup_cr_valid_i[p] && oup_cr_ready_o[p]) begin
                    given_q[p].push_back(oup_cr_resp_i[p]);
                    cr_cnt[p]++;
                end
                assert (ac_cnt[p] - cr_cnt[p] <= `SNOOP_PORT_MAX_OUT)
                    else report_problem($sformatf("port %0d has too many snoops outstanding", p));
                while (obs_ac_q[p].size() > 0 && exp_ac_q[p].size() > 0) begin
                    exp_word = exp_ac_q[p].pop_front();
                    obs_word = obs_ac_q[p].pop_front();
                    assert (obs_word == exp_word)
                        else report_mismatch($sformatf("oup_ac_addr_o/type_o[%0d]", p),
                                             exp_word, obs_word);
                end
                assert (obs_ac_q[p].size() <= 1)
                    else report_problem($sformatf("port %0d got a snoop outside its mask", p));
            end
            for (int r = 0; r < `SNOOP_NUM_INP; r++) begin
                if (inp_cr_valid_o[r] && inp_cr_ready_i[r]) begin
                    check_response(r);
                end
            end
        end
    end

    assert property (@(posedge clk_i) !arst_n_i |-> (inp_ac_ready_o == '0 &&
                     inp_cr_valid_o == '0 && oup_ac_valid_o == '0 && !cm_valid_o))
        else report_problem("a valid output is high during reset");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     cm_valid_o && $past(cm_valid_o) |-> $stable(cm_addr_o))
        else report_problem("cm_addr_o changed while cm_valid_o stayed high");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     cm_valid_o && cm_stall_i |=> cm_valid_o)
        else report_problem("arbiter left the fork state while cm_stall_i was high");

    for (genvar g = 0; g < `SNOOP_NUM_OUP; g++) begin : gen_port_checks
        initial run_snooper(g);

        assert property (@(posedge clk_i) disable iff (!arst_n_i)
                         oup_ac_valid_o[g] && !oup_ac_ready_i[g] |=> oup_ac_valid_o[g] &&
                         $stable(oup_ac_addr_o[g]) && $stable(oup_ac_type_o[g]))
            else report_problem($sformatf("oup_ac_valid_o[%0d] dropped or changed before transfer", g));

        assert property (@(posedge clk_i) disable iff (!arst_n_i)
                         cm_stall_i |=> !$rose(oup_ac_valid_o[g]))
            else report_problem($sformatf("oup_ac_valid_o[%0d] rose from a stalled fork", g));
    end

    for (genvar g = 0; g < `SNOOP_NUM_INP; g++) begin : gen_req_checks
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
                         inp_cr_valid_o[g] && !inp_cr_ready_i[g] |=>
                         inp_cr_valid_o[g] && $stable(inp_cr_resp_o[g]))
            else report_problem($sformatf("inp_cr_valid_o[%0d] dropped or changed before transfer", g));
    end

    task automatic run_snooper(input int p);
        int pend;
        bit cr_done;
        pend = 0;
        forever begin
            @(negedge clk_i);
            if (oup_ac_valid_o[p] && oup_ac_ready_i[p]) begin
                pend++;
            end
            cr_done = oup_cr_valid_i[p] && oup_cr_ready_o[p];
            if (cr_done) begin
                pend--;
            end
            @(posedge clk_i);
            #1;
            oup_ac_ready_i[p] = stress_mode ? ($urandom_range(0, 2) != 0) : 1'b1;
            if (cr_done) begin
                oup_cr_valid_i[p] = 1'b0;
            end
            // Answers go back in the order the snoops came in
            if (!oup_cr_valid_i[p] && pend > 0 && (!stress_mode || $urandom_range(0, 1) == 0)) begin
                oup_cr_valid_i[p] = 1'b1;
                oup_cr_resp_i[p]  = snoop_resp_t'($urandom);
            end
        end
    endtask

    task automatic drive_backpressure();
        forever begin
            @(posedge clk_i);
            #1;
            if (stress_mode) begin
                cm_stall_i = ($urandom_range(0, 3) == 0);
                for (int r = 0; r < `SNOOP_NUM_INP; r++) begin
                    inp_cr_ready_i[r] = ($urandom_range(0, 2) != 0);
                end
            end else begin
                cm_stall_i     = 1'b0;
                inp_cr_ready_i = '1;
            end
        end
    endtask

    initial drive_backpressure();

    task automatic issue_snoops(input int r, input int count);
        int cyc;
        bit got;
        for (int n = 0; n < count && !timed_out; n++) begin
            repeat ($urandom_range(0, 3)) @(posedge clk_i);
            @(posedge clk_i);
            #1;
            inp_ac_valid_i[r] = 1'b1;
            inp_ac_addr_i[r]  = snoop_addr_t'($urandom);
            inp_ac_type_i[r]  = snoop_type_t'($urandom);
            // About one in four snoops selects no cache
            inp_sel_i[r]      = ($urandom_range(0, 3) == 0) ? '0 : oup_sel_t'($urandom);
            got = 1'b0;
            cyc = 0;
            while (!got && cyc < ACK_TIMEOUT) begin
                @(negedge clk_i);
                got = inp_ac_ready_o[r];
                cyc++;
            end
            @(posedge clk_i);
            #1;
            inp_ac_valid_i[r] = 1'b0;
            if (!got) begin
                timed_out = 1'b1;
                report_problem($sformatf("requester %0d saw no inp_ac_ready_o in time", r));
            end
        end
        issuers_done++;
    endtask

    task automatic check_drained();
        assert (grant_idx_q.size() == 0)
            else report_problem($sformatf("%0d snoops got no response", grant_idx_q.size()));
        for (int p = 0; p < `SNOOP_NUM_OUP; p++) begin
            assert (exp_ac_q[p].size() == 0)
                else report_problem($sformatf("port %0d never saw %0d snoops", p, exp_ac_q[p].size()));
            assert (obs_ac_q[p].size() == 0)
                else report_problem($sformatf("port %0d saw snoops outside its mask", p));
            assert (given_q[p].size() == 0)
                else report_problem($sformatf("port %0d has snooper answers never merged", p));
        end
    endtask

    task automatic check_reset_values();
        int err_start;
        err_start = err_cnt;
        @(negedge clk_i);
        assert (inp_ac_ready_o == '0) else report_mismatch("inp_ac_ready_o", 0, inp_ac_ready_o);
        assert (inp_cr_valid_o == '0) else report_mismatch("inp_cr_valid_o", 0, inp_cr_valid_o);
        assert (oup_ac_valid_o == '0) else report_mismatch("oup_ac_valid_o", 0, oup_ac_valid_o);
        assert (!cm_valid_o) else report_mismatch("cm_valid_o", 0, cm_valid_o);
        report_test("reset_values", 0, err_start);
    endtask

    task automatic run_phase(input string name, input bit stress, input int per_req);
        int err_start;
        int target;
        int cyc;
        err_start    = err_cnt;
        stress_mode  = stress;
        target       = resp_cnt + `SNOOP_NUM_INP * per_req;
        issuers_done = 0;
        for (int r = 0; r < `SNOOP_NUM_INP; r++) begin
            fork
                automatic int rr = r;
                issue_snoops(rr, per_req);
            join_none
        end
        cyc = 0;
        while (issuers_done < `SNOOP_NUM_INP && cyc < ISSUE_TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
        end
        if (issuers_done < `SNOOP_NUM_INP) begin
            timed_out = 1'b1;
            report_problem("requesters did not finish issuing their snoops in time");
        end
        cyc = 0;
        while (!timed_out && resp_cnt < target && cyc < DRAIN_TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
        end
        if (!timed_out && resp_cnt < target) begin
            timed_out = 1'b1;
            report_problem($sformatf("only %0d of %0d responses arrived", resp_cnt, target));
        end
        // Quiet window so stray responses still get caught
        repeat (20) @(negedge clk_i);
        check_drained();
        report_test(name, `SNOOP_NUM_INP * per_req, err_start);
    endtask

    initial begin
        void'($urandom(32'hcff79f95));
        clk_i          = 1'b0;
        arst_n_i       = 1'b1;
        inp_ac_valid_i = '0;
        inp_ac_addr_i  = '0;
        inp_ac_type_i  = '0;
        inp_sel_i      = '0;
        inp_cr_ready_i = '1;
        oup_ac_ready_i = '0;
        oup_cr_valid_i = '0;
        oup_cr_resp_i  = '0;
        cm_stall_i     = 1'b0;
        err_cnt        = 0;
        resp_cnt       = 0;
        tests_run      = 0;
        tests_failed   = 0;
        issuers_done   = 0;
        timed_out      = 1'b0;
        stress_mode    = 1'b0;
        cm_seen        = 1'b0;
        last_cm_addr   = '0;
        for (int p = 0; p < `SNOOP_NUM_OUP; p++) begin
            ac_cnt[p] = 0;
            cr_cnt[p] = 0;
        end
        #2;
        arst_n_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check_reset_values();
        run_phase("light_traffic", 1'b0, 8);
        if (!timed_out) begin
            run_phase("stress_traffic", 1'b1, 60);
        end
        $display("summary: %0d tests run, %0d failed, %0d errors, %0d responses checked",
                 tests_run, tests_failed, err_cnt, resp_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
